// File: build.f
+incdir+source
source/vector_mod_pkg.sv
source/scalar_mod.sv
source/vector_mod_ctrl.sv
source/vector_mod_top.sv
tb/vector_mod_sva.sv
tb/vector_mod_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module vector_mod_tb \
  -Mdir obj_dir -o vector_mod_sim
./obj_dir/vector_mod_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// File: source/scalar_mod.sv
`timescale 1ns/1ns

`include "vector_mod_consts.svh"

module scalar_mod
  import vector_mod_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  vm_operands_t              operands,
  output logic                      done,
  output logic [`VM_DATA_WIDTH-1:0] remainder
);

  localparam int W     = `VM_DATA_WIDTH;
  localparam int CNT_W = $clog2(`VM_MOD_CYCLES);

  ////////////////////
  // Signals
  ////////////////////

  // Run control
  logic             busy;
  logic [CNT_W-1:0] iter_cnt;
  logic             last_iter;

  // Dividend bits still to shift in, MSB first
  logic [W-1:0] dividend_sr;

  // Partial remainder
  logic [W-1:0] rem_q;

  // One restoring step
  logic [W:0]   trial;
  logic [W-1:0] diff;
  logic         fits;
  logic [W-1:0] rem_next;

  ////////////////////
  // Step logic
  ////////////////////

  // Shift the next dividend bit under the partial remainder
  assign trial = {rem_q, dividend_sr[W-1]};
  assign diff  = trial[W-1:0] - operands.modulus;

  // Zero modulus always fits and subtracts nothing
  assign fits     = (trial >= {1'b0, operands.modulus});
  assign rem_next = fits ? diff : trial[W-1:0];

  assign last_iter = (iter_cnt == CNT_W'(`VM_MOD_CYCLES - 1));

  ////////////////////
  // Run control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      iter_cnt <= '0;
      done     <= 1'b0;
    end else begin
      // Done is a single-cycle pulse
      done <= 1'b0;
      if (start) begin
        busy     <= 1'b1;
        iter_cnt <= '0;
      end else if (busy) begin
        iter_cnt <= iter_cnt + 1'b1;
        if (last_iter) begin
          // Final step lands together with done
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge CLK) begin
    if (start) begin
      dividend_sr <= operands.data;
      rem_q       <= '0;
    end else if (busy) begin
      dividend_sr <= {dividend_sr[W-2:0], 1'b0};
      rem_q       <= rem_next;
    end
  end

  // Held after done until the next start
  assign remainder = rem_q;

endmodule

// File: source/vector_mod_consts.svh
`ifndef VECTOR_MOD_CONSTS_SVH
`define VECTOR_MOD_CONSTS_SVH

// Data, modulus and remainder word width
`define VM_DATA_WIDTH 16

// Vector length field and element index width
`define VM_LEN_WIDTH 8

// Engine iterations per element
// One quotient bit per cycle, so equal to the data width
`define VM_MOD_CYCLES `VM_DATA_WIDTH

`endif

// File: source/vector_mod_ctrl.sv
`timescale 1ns/1ns

`include "vector_mod_consts.svh"

module vector_mod_ctrl
  import vector_mod_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  input  logic [`VM_LEN_WIDTH-1:0]  size,
  input  logic                      data_in_enable,
  input  vm_operands_t              operands,
  output logic                      mod_start,
  output vm_operands_t              mod_operands,
  input  logic                      mod_done,
  input  logic [`VM_DATA_WIDTH-1:0] mod_remainder,
  output logic                      data_out_enable,
  output vm_result_t                result,
  output logic                      ready
);

  ////////////////////
  // Signals
  ////////////////////

  vm_state_t state;

  // Vector length latched on START
  logic [`VM_LEN_WIDTH-1:0] size_q;

  // Index of the element in flight
  logic [`VM_LEN_WIDTH-1:0] elem_idx;

  // Element in flight is the final one
  logic last_elem;

  // Strobe counts only while waiting for input
  logic accept;

  assign accept    = (state == WAIT_INPUT) && data_in_enable;
  assign last_elem = (elem_idx == (size_q - `VM_LEN_WIDTH'(1)));

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= IDLE;
      size_q          <= '0;
      elem_idx        <= '0;
      mod_start       <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      result          <= '0;
    end else begin
      // Pulses default low
      mod_start       <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      case (state)
        IDLE: begin
          // New vector
          if (start) begin
            size_q   <= size;
            elem_idx <= '0;
            state    <= WAIT_INPUT;
          end
        end
        WAIT_INPUT: begin
          // Launch engine on every element
          if (data_in_enable) begin
            mod_start <= 1'b1;
            state     <= WAIT_ENGINE;
          end
        end
        WAIT_ENGINE: begin
          if (mod_done) begin
            result.value    <= mod_remainder;
            result.last     <= last_elem;
            data_out_enable <= 1'b1;
            if (last_elem) begin
              // Vector complete
              ready <= 1'b1;
              state <= IDLE;
            end else begin
              elem_idx <= elem_idx + 1'b1;
              state    <= WAIT_INPUT;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Operand latch
  ////////////////////

  // Held steady for the whole engine run
  always_ff @(posedge CLK) begin
    if (accept) begin
      mod_operands <= operands;
    end
  end

endmodule

// File: source/vector_mod_pkg.sv
`include "vector_mod_consts.svh"

package vector_mod_pkg;

  ////////////////////
  // Element bundles
  ////////////////////

  // One vector element as presented by the host
  typedef struct packed {
    logic [`VM_DATA_WIDTH-1:0] modulus;
    logic [`VM_DATA_WIDTH-1:0] data;
  } vm_operands_t;

  // Remainder plus end-of-vector flag
  typedef struct packed {
    logic [`VM_DATA_WIDTH-1:0] value;
    logic                      last;
  } vm_result_t;

  ////////////////////
  // Control FSM
  ////////////////////

  // Idle until START, then alternate input / engine wait
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    WAIT_INPUT  = 2'd1,
    WAIT_ENGINE = 2'd2
  } vm_state_t;

endpackage

// File: source/vector_mod_top.sv
`timescale 1ns/1ns

`include "vector_mod_consts.svh"

module vector_mod_top
  import vector_mod_pkg::*;
(
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     start,
  input  logic [`VM_LEN_WIDTH-1:0] size,
  input  logic                     data_in_enable,
  input  vm_operands_t             operands,
  output logic                     data_out_enable,
  output vm_result_t               result,
  output logic                     ready
);

  // Control to engine
  logic         mod_start;
  vm_operands_t mod_operands;

  // Engine to control
  logic                      mod_done;
  logic [`VM_DATA_WIDTH-1:0] mod_remainder;

  // Element sequencing and result register
  vector_mod_ctrl u_ctrl (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .size            (size),
    .data_in_enable  (data_in_enable),
    .operands        (operands),
    .mod_start       (mod_start),
    .mod_operands    (mod_operands),
    .mod_done        (mod_done),
    .mod_remainder   (mod_remainder),
    .data_out_enable (data_out_enable),
    .result          (result),
    .ready           (ready)
  );

  // Scalar remainder engine
  scalar_mod u_scalar_mod (
    .CLK       (CLK),
    .RST       (RST),
    .start     (mod_start),
    .operands  (mod_operands),
    .done      (mod_done),
    .remainder (mod_remainder)
  );

endmodule

// File: tb/vector_mod_input.txt
# V <length>                        one vector of that many elements, hex
# E <modulus> <data> <expected>     one element, all hex, expected = data mod modulus
V 1
E 0007 0064 0002
V 4
E 000A 0003 0003
E 000A 000A 0000
E 000A 0050 0000
E 0000 1234 1234
V 3
E FFFF FFFF 0000
E FFFF FFFE FFFE
E 0001 ABCD 0000
V 5
E 0003 FFFF 0000
E 0010 1235 0005
E 0100 BEEF 00EF
E 8000 FFFF 7FFF
E 00FF 1234 0046
V 2
E 0000 0000 0000
E 0000 FFFF FFFF
V 4
E 03E8 2710 0000
E 0007 0006 0006
E 1000 F123 0123
E 0009 0064 0001
V 1
E 000D 00C8 0005
V 3
E 7FFF FFFF 0001
E 0002 8001 0001
E 00C8 00C7 00C7

// File: tb/vector_mod_sva.sv
`timescale 1ns/1ns

`include "vector_mod_consts.svh"

module vector_mod_sva
  import vector_mod_pkg::*;
(
  input logic       CLK,
  input logic       RST,
  input logic       data_in_enable,
  input logic       data_out_enable,
  input logic       ready,
  input vm_result_t result,
  input vm_state_t  state
);

  localparam int LATENCY = `VM_MOD_CYCLES + 2;

  // Strobe only counts in WAIT_INPUT
  logic accept;
  assign accept = (state == WAIT_INPUT) && data_in_enable;

  ////////////////////
  // Output timing
  ////////////////////

  // Pulse set at strobe edge + 18 and sampled one edge later
  a_latency: assert property (@(posedge CLK) disable iff (RST)
    accept |-> ##(LATENCY + 1) data_out_enable)
    else $error("data_out_enable missing after accepted strobe");

  a_no_stray_out: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> $past(accept, LATENCY + 1))
    else $error("data_out_enable without a matching strobe");

  // End of vector
  a_ready_last: assert property (@(posedge CLK) disable iff (RST)
    ready |-> (data_out_enable && result.last))
    else $error("ready without data_out_enable and last");

  a_out_pulse: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |=> !data_out_enable)
    else $error("data_out_enable longer than one cycle");

  a_ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else $error("ready longer than one cycle");

endmodule

bind vector_mod_top vector_mod_sva u_sva (
  .CLK             (CLK),
  .RST             (RST),
  .data_in_enable  (data_in_enable),
  .data_out_enable (data_out_enable),
  .ready           (ready),
  .result          (result),
  .state           (u_ctrl.state)
);

// File: tb/vector_mod_tb.sv
`timescale 1ns/1ns

`include "vector_mod_consts.svh"

module vector_mod_tb
  import vector_mod_pkg::*;
();

  // Strobe edge to result edge
  localparam int LATENCY = `VM_MOD_CYCLES + 2;
  localparam int MAX_GAP = 5;

  ////////////////////
  // DUT signals
  ////////////////////

  logic                     CLK;
  logic                     RST;
  logic                     start;
  logic [`VM_LEN_WIDTH-1:0] size;
  logic                     data_in_enable;
  vm_operands_t             operands;
  logic                     data_out_enable;
  vm_result_t               result;
  logic                     ready;

  // Vector lengths and the elements flattened in file order
  int                        vec_len_q[$];
  logic [`VM_DATA_WIDTH-1:0] mod_q[$];
  logic [`VM_DATA_WIDTH-1:0] data_q[$];
  logic [`VM_DATA_WIDTH-1:0] exp_q[$];

  integer seed = 32'h3a9d_a54d;
  int     cycle_cnt = 0;
  int     timeout_limit = 0;

  vector_mod_top u_dut (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .size            (size),
    .data_in_enable  (data_in_enable),
    .operands        (operands),
    .data_out_enable (data_out_enable),
    .result          (result),
    .ready           (ready)
  );

  // 40 ns period
  always #20 CLK = ~CLK;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  // No result and no end-of-vector pulse
  task automatic check_quiet();
    check_value("data_out_enable", data_out_enable, 0);
    check_value("ready", ready, 0);
  endtask

  // Watchdog
  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
      abort_run($sformatf("Timeout: vectors not finished after %0d cycles", cycle_cnt));
    end
  end

  ////////////////////
  // Stimulus file
  ////////////////////

  task automatic load_vectors();
    int                        fd;
    int                        len;
    int                        pending;
    string                     line;
    logic [`VM_DATA_WIDTH-1:0] m;
    logic [`VM_DATA_WIDTH-1:0] d;
    logic [`VM_DATA_WIDTH-1:0] e;
    logic [`VM_DATA_WIDTH-1:0] rule;
    pending = 0;
    fd = $fopen("tb/vector_mod_input.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the stimulus file tb/vector_mod_input.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "V %h", len) == 1) begin
        if (pending != 0 || len < 1) begin
          abort_run("Stimulus file has a bad vector length or a short vector");
        end
        vec_len_q.push_back(len);
        pending = len;
      end else if ($sscanf(line, "E %h %h %h", m, d, e) == 3) begin
        // Zero modulus passes data through and any other gives data mod modulus
        rule = (m == '0) ? d : d % m;
        if (pending == 0 || e !== rule) begin
          abort_run($sformatf("Stimulus file has a bad element line: %s", line));
        end
        pending--;
        mod_q.push_back(m);
        data_q.push_back(d);
        exp_q.push_back(e);
      end
    end
    $fclose(fd);
    if (pending != 0) begin
      abort_run("Stimulus file ends inside a vector");
    end
  endtask

  ////////////////////
  // Element driver
  ////////////////////

  task automatic run_element(input int idx, input bit is_last, input bit disturb);
    int gap;
    int n;
    bit seen;
    gap = $unsigned($random(seed)) % (MAX_GAP + 1);
    repeat (gap) begin
      @(posedge CLK);
      check_quiet();
    end
    @(posedge CLK);
    check_quiet();
    data_in_enable   <= 1'b1;
    operands.modulus <= mod_q[idx];
    operands.data    <= data_q[idx];
    // Strobe sampled here
    @(posedge CLK);
    check_quiet();
    data_in_enable <= 1'b0;
    n = 0;
    seen = 0;
    while (!seen) begin
      @(posedge CLK);
      n++;
      // Stray START and strobe while the engine runs
      if (disturb) begin
        if (n == 3) begin
          start <= 1'b1;
          size  <= '1;
        end
        if (n == 4) start <= 1'b0;
        if (n == 6) begin
          data_in_enable <= 1'b1;
          operands       <= vm_operands_t'($random(seed));
        end
        if (n == 7) data_in_enable <= 1'b0;
      end
      if (data_out_enable) begin
        seen = 1;
      end else begin
        check_value("ready", ready, 0);
        if (n >= LATENCY + 1) check_value("data_out_enable", 0, 1);
      end
    end
    // Registered at strobe edge + 18 and seen one edge later
    check_value("latency", n, LATENCY + 1);
    check_value("result.value", result.value, exp_q[idx]);
    check_value("result.last", result.last, is_last);
    check_value("ready", ready, is_last);
  endtask

  task automatic run_vector(input int len, input int base);
    int i;
    @(posedge CLK);
    check_quiet();
    start <= 1'b1;
    size  <= `VM_LEN_WIDTH'(len);
    @(posedge CLK);
    check_quiet();
    start <= 1'b0;
    for (i = 0; i < len; i++) begin
      run_element(base + i, i == len - 1, (i % 2) == 1);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int base;
    int v;
    CLK            = 1'b0;
    RST            = 1'b1;
    start          = 1'b0;
    size           = '0;
    data_in_enable = 1'b0;
    operands       = '0;
    load_vectors();
    timeout_limit = exp_q.size() * (`VM_MOD_CYCLES + 2 + 5 + 4) + 100;
    repeat (5) @(posedge CLK);
    RST <= 1'b0;
    // Quiet and cleared out of reset
    repeat (3) begin
      @(posedge CLK);
      check_quiet();
      check_value("result", result, '0);
    end
    base = 0;
    for (v = 0; v < vec_len_q.size(); v++) begin
      run_vector(vec_len_q[v], base);
      base += vec_len_q[v];
    end
    // Strobe in IDLE must be dropped
    @(posedge CLK);
    check_quiet();
    data_in_enable <= 1'b1;
    @(posedge CLK);
    check_quiet();
    data_in_enable <= 1'b0;
    repeat (LATENCY + 4) begin
      @(posedge CLK);
      check_quiet();
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
